// ==== rtl/riscv_mw_pkg.sv ====
package riscv_mw_pkg;

    localparam int XLEN     = 64;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [REG_AW-1:0] regaddr_t;
    typedef logic [2:0]        resultsrc_t;
    typedef logic [2:0]        loadsel_t;
    typedef logic [1:0]        trapret_t;

    // writeback source, codes 5..7 give zero
    localparam resultsrc_t RES_ALU  = 3'd0;
    localparam resultsrc_t RES_MEM  = 3'd1;
    localparam resultsrc_t RES_PC4  = 3'd2;
    localparam resultsrc_t RES_UIMM = 3'd3;
    localparam resultsrc_t RES_SC   = 3'd4;

    // load type, same as funct3
    localparam loadsel_t LD_B  = 3'd0;
    localparam loadsel_t LD_H  = 3'd1;
    localparam loadsel_t LD_W  = 3'd2;
    localparam loadsel_t LD_D  = 3'd3;
    localparam loadsel_t LD_BU = 3'd4;
    localparam loadsel_t LD_HU = 3'd5;
    localparam loadsel_t LD_WU = 3'd6;

endpackage

// ==== rtl/riscv_load_align.sv ====
`timescale 1ns/100ps

module riscv_load_align import riscv_mw_pkg::*; (
    input  xlen_t    i_riscv_mw_memrdata,
    input  xlen_t    i_riscv_mw_memaddr,
    input  loadsel_t i_riscv_mw_loadsel,
    output xlen_t    o_riscv_mw_memload
);

    logic [5:0] lane_shift;
    xlen_t      lane_data;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;

    assign lane_shift = {i_riscv_mw_memaddr[2:0], 3'b000}; // byte offset in bits
    assign lane_data  = i_riscv_mw_memrdata >> lane_shift;

    assign lane_b = lane_data[7:0];
    assign lane_h = lane_data[15:0];
    assign lane_w = lane_data[31:0];

    always_comb begin
        case (i_riscv_mw_loadsel)
            LD_B: begin
                o_riscv_mw_memload = {{56{lane_b[7]}}, lane_b};
            end
            LD_H: begin
                o_riscv_mw_memload = {{48{lane_h[15]}}, lane_h};
            end
            LD_W: begin
                o_riscv_mw_memload = {{32{lane_w[31]}}, lane_w};
            end
            LD_D: begin
                o_riscv_mw_memload = i_riscv_mw_memrdata; // full doubleword
            end
            LD_BU: begin
                o_riscv_mw_memload = {56'b0, lane_b};
            end
            LD_HU: begin
                o_riscv_mw_memload = {48'b0, lane_h};
            end
            LD_WU: begin
                o_riscv_mw_memload = {32'b0, lane_w};
            end
            default: begin
                o_riscv_mw_memload = '0; // funct3 7 is not a load
            end
        endcase
    end

endmodule

// ==== rtl/riscv_ppreg_mw.sv ====
`timescale 1ns/100ps

module riscv_ppreg_mw import riscv_mw_pkg::*; (
    input  logic       i_riscv_mw_clk,
    input  logic       i_riscv_mw_rst,
    input  logic       i_riscv_mw_en,          // high stalls
    input  logic       i_riscv_mw_flush,
    input  xlen_t      i_riscv_mw_pcplus4_m,
    input  xlen_t      i_riscv_mw_result_m,
    input  xlen_t      i_riscv_mw_uimm_m,
    input  xlen_t      i_riscv_mw_memload_m,
    input  xlen_t      i_riscv_mw_rddata_sc_m,
    input  xlen_t      i_riscv_mw_csrout_m,
    input  regaddr_t   i_riscv_mw_rdaddr_m,
    input  resultsrc_t i_riscv_mw_resultsrc_m,
    input  logic       i_riscv_mw_regw_m,
    input  logic       i_riscv_mw_iscsr_m,
    input  logic       i_riscv_mw_gototrap_m,
    input  logic       i_riscv_mw_instret_m,
    input  trapret_t   i_riscv_mw_returnfromtrap_m,
    output xlen_t      o_riscv_mw_pcplus4_wb,
    output xlen_t      o_riscv_mw_result_wb,
    output xlen_t      o_riscv_mw_uimm_wb,
    output xlen_t      o_riscv_mw_memload_wb,
    output xlen_t      o_riscv_mw_rddata_sc_wb,
    output xlen_t      o_riscv_mw_csrout_wb,
    output regaddr_t   o_riscv_mw_rdaddr_wb,
    output resultsrc_t o_riscv_mw_resultsrc_wb,
    output logic       o_riscv_mw_regw_wb,
    output logic       o_riscv_mw_iscsr_wb,
    output logic       o_riscv_mw_gototrap_wb,
    output logic       o_riscv_mw_instret_wb,
    output trapret_t   o_riscv_mw_returnfromtrap_wb
);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin : mw_reg_proc
        if (i_riscv_mw_rst || i_riscv_mw_flush) begin
            o_riscv_mw_pcplus4_wb        <= '0;
            o_riscv_mw_result_wb         <= '0;
            o_riscv_mw_uimm_wb           <= '0;
            o_riscv_mw_memload_wb        <= '0;
            o_riscv_mw_rddata_sc_wb      <= '0;
            o_riscv_mw_csrout_wb         <= '0;
            o_riscv_mw_rdaddr_wb         <= '0;
            o_riscv_mw_resultsrc_wb      <= '0;
            o_riscv_mw_regw_wb           <= 1'b0;
            o_riscv_mw_iscsr_wb          <= 1'b0;
            o_riscv_mw_gototrap_wb       <= 1'b0;
            o_riscv_mw_instret_wb        <= 1'b0;
            o_riscv_mw_returnfromtrap_wb <= '0;
        end else if (!i_riscv_mw_en) begin
            o_riscv_mw_pcplus4_wb        <= i_riscv_mw_pcplus4_m;
            o_riscv_mw_result_wb         <= i_riscv_mw_result_m;
            o_riscv_mw_uimm_wb           <= i_riscv_mw_uimm_m;
            o_riscv_mw_memload_wb        <= i_riscv_mw_memload_m;
            o_riscv_mw_rddata_sc_wb      <= i_riscv_mw_rddata_sc_m;
            o_riscv_mw_csrout_wb         <= i_riscv_mw_csrout_m;
            o_riscv_mw_rdaddr_wb         <= i_riscv_mw_rdaddr_m;
            o_riscv_mw_resultsrc_wb      <= i_riscv_mw_resultsrc_m;
            o_riscv_mw_regw_wb           <= i_riscv_mw_regw_m;
            o_riscv_mw_iscsr_wb          <= i_riscv_mw_iscsr_m;
            o_riscv_mw_gototrap_wb       <= i_riscv_mw_gototrap_m;
            o_riscv_mw_instret_wb        <= i_riscv_mw_instret_m;
            o_riscv_mw_returnfromtrap_wb <= i_riscv_mw_returnfromtrap_m;
        end else begin
            // held instruction must not retire twice
            o_riscv_mw_instret_wb        <= 1'b0;
        end
    end

endmodule

// ==== rtl/riscv_wb_select.sv ====
`timescale 1ns/100ps

module riscv_wb_select import riscv_mw_pkg::*; (
    input  xlen_t      i_riscv_mw_result,
    input  xlen_t      i_riscv_mw_memload,
    input  xlen_t      i_riscv_mw_pcplus4,
    input  xlen_t      i_riscv_mw_uimm,
    input  xlen_t      i_riscv_mw_rddata_sc,
    input  xlen_t      i_riscv_mw_csrout,
    input  resultsrc_t i_riscv_mw_resultsrc,
    input  logic       i_riscv_mw_iscsr,
    input  logic       i_riscv_mw_regw,
    input  logic       i_riscv_mw_gototrap,
    input  regaddr_t   i_riscv_mw_rdaddr,
    output xlen_t      o_riscv_mw_wbdata,
    output logic       o_riscv_mw_regwe
);

    xlen_t src_data;

    always_comb begin
        case (i_riscv_mw_resultsrc)
            RES_ALU:  src_data = i_riscv_mw_result;
            RES_MEM:  src_data = i_riscv_mw_memload;
            RES_PC4:  src_data = i_riscv_mw_pcplus4;  // jal / jalr link
            RES_UIMM: src_data = i_riscv_mw_uimm;     // lui
            RES_SC:   src_data = i_riscv_mw_rddata_sc;
            default:  src_data = '0;
        endcase
    end

    assign o_riscv_mw_wbdata = i_riscv_mw_iscsr ? i_riscv_mw_csrout : src_data;

    // trapping instruction or x0 never writes
    assign o_riscv_mw_regwe = i_riscv_mw_regw
                            & ~i_riscv_mw_gototrap
                            & (i_riscv_mw_rdaddr != '0);

endmodule

// ==== rtl/riscv_regfile.sv ====
`timescale 1ns/100ps

module riscv_regfile import riscv_mw_pkg::*; (
    input  logic     i_riscv_mw_clk,
    input  logic     i_riscv_mw_rst,
    input  logic     i_riscv_mw_we,
    input  regaddr_t i_riscv_mw_waddr,
    input  xlen_t    i_riscv_mw_wdata,
    input  regaddr_t i_riscv_mw_rs1addr,
    input  regaddr_t i_riscv_mw_rs2addr,
    output xlen_t    o_riscv_mw_rs1data,
    output xlen_t    o_riscv_mw_rs2data
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin : rf_write_proc
        if (i_riscv_mw_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_riscv_mw_we) begin
            regs[i_riscv_mw_waddr] <= i_riscv_mw_wdata;
        end
    end

    always_comb begin
        if (i_riscv_mw_rs1addr == '0) begin
            o_riscv_mw_rs1data = '0;
        end else if (i_riscv_mw_we && (i_riscv_mw_waddr == i_riscv_mw_rs1addr)) begin
            o_riscv_mw_rs1data = i_riscv_mw_wdata; // bypass
        end else begin
            o_riscv_mw_rs1data = regs[i_riscv_mw_rs1addr];
        end
    end

    always_comb begin
        if (i_riscv_mw_rs2addr == '0) begin
            o_riscv_mw_rs2data = '0;
        end else if (i_riscv_mw_we && (i_riscv_mw_waddr == i_riscv_mw_rs2addr)) begin
            o_riscv_mw_rs2data = i_riscv_mw_wdata; // bypass
        end else begin
            o_riscv_mw_rs2data = regs[i_riscv_mw_rs2addr];
        end
    end

endmodule

// ==== rtl/riscv_mw_top.sv ====
`timescale 1ns/100ps

module riscv_mw_top import riscv_mw_pkg::*; (
    input  logic       i_riscv_mw_clk,
    input  logic       i_riscv_mw_rst,
    input  logic       i_riscv_mw_en,
    input  logic       i_riscv_mw_flush,
    input  xlen_t      i_riscv_mw_pcplus4_m,
    input  xlen_t      i_riscv_mw_result_m,
    input  xlen_t      i_riscv_mw_uimm_m,
    input  xlen_t      i_riscv_mw_memrdata_m,
    input  xlen_t      i_riscv_mw_memaddr_m,
    input  xlen_t      i_riscv_mw_rddata_sc_m,
    input  xlen_t      i_riscv_mw_csrout_m,
    input  loadsel_t   i_riscv_mw_loadsel_m,
    input  regaddr_t   i_riscv_mw_rdaddr_m,
    input  resultsrc_t i_riscv_mw_resultsrc_m,
    input  logic       i_riscv_mw_regw_m,
    input  logic       i_riscv_mw_iscsr_m,
    input  logic       i_riscv_mw_gototrap_m,
    input  trapret_t   i_riscv_mw_returnfromtrap_m,
    input  logic       i_riscv_mw_instret_m,
    input  regaddr_t   i_riscv_mw_rs1addr,
    input  regaddr_t   i_riscv_mw_rs2addr,
    output xlen_t      o_riscv_mw_wbdata,
    output regaddr_t   o_riscv_mw_rdaddr_wb,
    output logic       o_riscv_mw_regwe,
    output logic       o_riscv_mw_instret_wb,
    output logic       o_riscv_mw_gototrap_wb,
    output trapret_t   o_riscv_mw_returnfromtrap_wb,
    output xlen_t      o_riscv_mw_rs1data,
    output xlen_t      o_riscv_mw_rs2data
);

    xlen_t      memload_m;
    xlen_t      pcplus4_wb;
    xlen_t      result_wb;
    xlen_t      uimm_wb;
    xlen_t      memload_wb;
    xlen_t      rddata_sc_wb;
    xlen_t      csrout_wb;
    resultsrc_t resultsrc_wb;
    logic       regw_wb;
    logic       iscsr_wb;

    riscv_load_align u_load_align (
        .i_riscv_mw_memrdata (i_riscv_mw_memrdata_m),
        .i_riscv_mw_memaddr  (i_riscv_mw_memaddr_m),
        .i_riscv_mw_loadsel  (i_riscv_mw_loadsel_m),
        .o_riscv_mw_memload  (memload_m)
    );

    riscv_ppreg_mw u_ppreg_mw (
        .i_riscv_mw_clk               (i_riscv_mw_clk),
        .i_riscv_mw_rst               (i_riscv_mw_rst),
        .i_riscv_mw_en                (i_riscv_mw_en),
        .i_riscv_mw_flush             (i_riscv_mw_flush),
        .i_riscv_mw_pcplus4_m         (i_riscv_mw_pcplus4_m),
        .i_riscv_mw_result_m          (i_riscv_mw_result_m),
        .i_riscv_mw_uimm_m            (i_riscv_mw_uimm_m),
        .i_riscv_mw_memload_m         (memload_m),
        .i_riscv_mw_rddata_sc_m       (i_riscv_mw_rddata_sc_m),
        .i_riscv_mw_csrout_m          (i_riscv_mw_csrout_m),
        .i_riscv_mw_rdaddr_m          (i_riscv_mw_rdaddr_m),
        .i_riscv_mw_resultsrc_m       (i_riscv_mw_resultsrc_m),
        .i_riscv_mw_regw_m            (i_riscv_mw_regw_m),
        .i_riscv_mw_iscsr_m           (i_riscv_mw_iscsr_m),
        .i_riscv_mw_gototrap_m        (i_riscv_mw_gototrap_m),
        .i_riscv_mw_instret_m         (i_riscv_mw_instret_m),
        .i_riscv_mw_returnfromtrap_m  (i_riscv_mw_returnfromtrap_m),
        .o_riscv_mw_pcplus4_wb        (pcplus4_wb),
        .o_riscv_mw_result_wb         (result_wb),
        .o_riscv_mw_uimm_wb           (uimm_wb),
        .o_riscv_mw_memload_wb        (memload_wb),
        .o_riscv_mw_rddata_sc_wb      (rddata_sc_wb),
        .o_riscv_mw_csrout_wb         (csrout_wb),
        .o_riscv_mw_rdaddr_wb         (o_riscv_mw_rdaddr_wb),
        .o_riscv_mw_resultsrc_wb      (resultsrc_wb),
        .o_riscv_mw_regw_wb           (regw_wb),
        .o_riscv_mw_iscsr_wb          (iscsr_wb),
        .o_riscv_mw_gototrap_wb       (o_riscv_mw_gototrap_wb),
        .o_riscv_mw_instret_wb        (o_riscv_mw_instret_wb),
        .o_riscv_mw_returnfromtrap_wb (o_riscv_mw_returnfromtrap_wb)
    );

    riscv_wb_select u_wb_select (
        .i_riscv_mw_result    (result_wb),
        .i_riscv_mw_memload   (memload_wb),
        .i_riscv_mw_pcplus4   (pcplus4_wb),
        .i_riscv_mw_uimm      (uimm_wb),
        .i_riscv_mw_rddata_sc (rddata_sc_wb),
        .i_riscv_mw_csrout    (csrout_wb),
        .i_riscv_mw_resultsrc (resultsrc_wb),
        .i_riscv_mw_iscsr     (iscsr_wb),
        .i_riscv_mw_regw      (regw_wb),
        .i_riscv_mw_gototrap  (o_riscv_mw_gototrap_wb),
        .i_riscv_mw_rdaddr    (o_riscv_mw_rdaddr_wb),
        .o_riscv_mw_wbdata    (o_riscv_mw_wbdata),
        .o_riscv_mw_regwe     (o_riscv_mw_regwe)
    );

    riscv_regfile u_regfile (
        .i_riscv_mw_clk     (i_riscv_mw_clk),
        .i_riscv_mw_rst     (i_riscv_mw_rst),
        .i_riscv_mw_we      (o_riscv_mw_regwe),
        .i_riscv_mw_waddr   (o_riscv_mw_rdaddr_wb),
        .i_riscv_mw_wdata   (o_riscv_mw_wbdata),
        .i_riscv_mw_rs1addr (i_riscv_mw_rs1addr),
        .i_riscv_mw_rs2addr (i_riscv_mw_rs2addr),
        .o_riscv_mw_rs1data (o_riscv_mw_rs1data),
        .o_riscv_mw_rs2data (o_riscv_mw_rs2data)
    );

endmodule

// ==== tests/riscv_mw_tb.sv ====
`timescale 1ns/100ps

module riscv_mw_tb import riscv_mw_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int ROWS       = 128;

    logic       clk = 1'b0;
    logic       rst, en, flush, regw, iscsr, gototrap, instret;
    xlen_t      pcplus4, result, uimm, memrdata, memaddr, rddata_sc, csrout;
    loadsel_t   loadsel;
    regaddr_t   rdaddr, rs1addr, rs2addr;
    resultsrc_t resultsrc;
    trapret_t   rfret;
    xlen_t      wbdata, rs1data, rs2data;
    regaddr_t   rdaddr_wb;
    logic       regwe, instret_wb, gototrap_wb;
    trapret_t   rfret_wb;

    // stimulus table, row 0 is the empty (flushed) register content
    xlen_t      t_pc4 [ROWS], t_res [ROWS], t_uimm [ROWS], t_mdata [ROWS];
    xlen_t      t_maddr [ROWS], t_sc [ROWS], t_csr [ROWS];
    loadsel_t   t_ls [ROWS];
    resultsrc_t t_src [ROWS];
    regaddr_t   t_rd [ROWS], t_rs1 [ROWS], t_rs2 [ROWS];
    logic       t_regw [ROWS], t_csrsel [ROWS], t_trap [ROWS], t_ret [ROWS];
    logic       t_en [ROWS], t_flush [ROWS];
    trapret_t   t_rfret [ROWS];
    // expected values, one cycle after the row
    xlen_t      e_wb [ROWS], e_rs1 [ROWS], e_rs2 [ROWS];
    regaddr_t   e_rd [ROWS];
    logic       e_we [ROWS], e_ret [ROWS], e_trap [ROWS];
    trapret_t   e_rfret [ROWS];

    xlen_t      m_regs [NUM_REGS];  // register file model
    int         m_row;              // row held in the model pipeline register
    logic       m_ret;
    int         n_rows = 0;
    int         cur_row = 0;
    int         n_checks = 0;
    int         n_errors = 0;
    logic       table_ready = 1'b0;

    riscv_mw_top i_dut (
        .i_riscv_mw_clk               (clk),
        .i_riscv_mw_rst               (rst),
        .i_riscv_mw_en                (en),
        .i_riscv_mw_flush             (flush),
        .i_riscv_mw_pcplus4_m         (pcplus4),
        .i_riscv_mw_result_m          (result),
        .i_riscv_mw_uimm_m            (uimm),
        .i_riscv_mw_memrdata_m        (memrdata),
        .i_riscv_mw_memaddr_m         (memaddr),
        .i_riscv_mw_rddata_sc_m       (rddata_sc),
        .i_riscv_mw_csrout_m          (csrout),
        .i_riscv_mw_loadsel_m         (loadsel),
        .i_riscv_mw_rdaddr_m          (rdaddr),
        .i_riscv_mw_resultsrc_m       (resultsrc),
        .i_riscv_mw_regw_m            (regw),
        .i_riscv_mw_iscsr_m           (iscsr),
        .i_riscv_mw_gototrap_m        (gototrap),
        .i_riscv_mw_returnfromtrap_m  (rfret),
        .i_riscv_mw_instret_m         (instret),
        .i_riscv_mw_rs1addr           (rs1addr),
        .i_riscv_mw_rs2addr           (rs2addr),
        .o_riscv_mw_wbdata            (wbdata),
        .o_riscv_mw_rdaddr_wb         (rdaddr_wb),
        .o_riscv_mw_regwe             (regwe),
        .o_riscv_mw_instret_wb        (instret_wb),
        .o_riscv_mw_gototrap_wb       (gototrap_wb),
        .o_riscv_mw_returnfromtrap_wb (rfret_wb),
        .o_riscv_mw_rs1data           (rs1data),
        .o_riscv_mw_rs2data           (rs2data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // bytes taken one by one from the lane, bytes past the doubleword read zero
    function automatic xlen_t load_value(xlen_t data, logic [2:0] off, loadsel_t ls);
        xlen_t v;
        int    nb;
        logic  sgn;
        if (ls == LD_D) begin
            return data;
        end
        v  = '0;
        nb = 1 << ls[1:0];
        for (int j = 0; j < 8; j++) begin
            if (j < nb && int'(off) + j < 8) begin
                v[8*j +: 8] = data[8*(int'(off) + j) +: 8];
            end
        end
        sgn = ls[2] ? 1'b0 : v[8*nb-1];
        for (int b = 8 * nb; b < 64; b++) begin
            v[b] = sgn;
        end
        return v;
    endfunction

    function automatic xlen_t wb_of(int r);
        if (t_csrsel[r]) begin
            return t_csr[r];
        end
        case (t_src[r])
            RES_ALU:  return t_res[r];
            RES_MEM:  return load_value(t_mdata[r], t_maddr[r][2:0], t_ls[r]);
            RES_PC4:  return t_pc4[r];
            RES_UIMM: return t_uimm[r];
            RES_SC:   return t_sc[r];
            default:  return '0;
        endcase
    endfunction

    function automatic logic we_of(int r);
        return t_regw[r] && !t_trap[r] && (t_rd[r] != '0);
    endfunction

    function automatic xlen_t read_of(regaddr_t a);
        if (a == '0) begin
            return '0;
        end
        if (we_of(m_row) && t_rd[m_row] == a) begin
            return wb_of(m_row); // same-cycle bypass
        end
        return m_regs[a];
    endfunction

    task automatic add_row(int ls, int off, int src, int csr, int regw_i, int trap, int ret,
                           int rd, int stall, int flsh, int rs1, int rs2);
        int n;
        n = n_rows;
        t_ls[n]     = ls[2:0];
        t_src[n]    = src[2:0];
        t_csrsel[n] = csr[0];
        t_regw[n]   = regw_i[0];
        t_trap[n]   = trap[0];
        t_ret[n]    = ret[0];
        t_rd[n]     = rd[4:0];
        t_en[n]     = stall[0];
        t_flush[n]  = flsh[0];
        t_rs1[n]    = rs1[4:0];
        t_rs2[n]    = rs2[4:0];
        t_pc4[n]    = {$urandom, $urandom};
        t_res[n]    = {$urandom, $urandom};
        t_uimm[n]   = {$urandom, $urandom};
        t_mdata[n]  = {$urandom, $urandom};
        t_maddr[n]  = {$urandom, $urandom};
        t_maddr[n][2:0] = off[2:0];
        t_sc[n]     = {$urandom, $urandom};
        t_csr[n]    = {$urandom, $urandom};
        t_rfret[n]  = 2'($urandom);
        if (we_of(m_row)) begin
            m_regs[t_rd[m_row]] = wb_of(m_row); // write at the edge ending writeback
        end
        if (t_flush[n]) begin
            m_row = 0;
            m_ret = 1'b0;
        end else if (!t_en[n]) begin
            m_row = n;
            m_ret = t_ret[n];
        end else begin
            m_ret = 1'b0; // stalled, no second retire
        end
        e_wb[n]    = wb_of(m_row);
        e_we[n]    = we_of(m_row);
        e_rd[n]    = t_rd[m_row];
        e_trap[n]  = t_trap[m_row];
        e_rfret[n] = t_rfret[m_row];
        e_ret[n]   = m_ret;
        e_rs1[n]   = read_of(t_rs1[n]);
        e_rs2[n]   = read_of(t_rs2[n]);
        n_rows     = n + 1;
    endtask

    task automatic build_table();
        for (int a = 0; a < NUM_REGS; a++) begin
            m_regs[a] = '0;
        end
        m_row = 0;
        add_row(7, 0, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0); // undefined source reads as zero
        t_rfret[0] = '0;
        for (int k = 0; k < 56; k++) begin
            add_row(k / 8, k % 8, int'(RES_MEM), 0, 1, 0, 1, 1 + k % 31, 0, 0, 1 + k % 31, 0);
        end
        for (int k = 0; k < 8; k++) begin
            add_row(3, k, k, 0, 1, 0, 1, 8 + k, 0, 0, 1, 2 + k);
        end
        add_row(3, 0, int'(RES_MEM), 1, 1, 0, 1, 16, 0, 0, 16, 1); // csr wins
        add_row(3, 0, 6, 1, 1, 0, 1, 17, 0, 0, 17, 16);
        add_row(3, 0, 0, 0, 1, 0, 1, 20, 0, 0, 20, 0);
        add_row(3, 0, 0, 0, 1, 1, 1, 20, 0, 0, 20, 21);  // trap blocks the write
        add_row(3, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 20);    // rd = x0
        add_row(3, 0, 0, 0, 0, 0, 1, 21, 0, 0, 21, 20);
        add_row(3, 0, 0, 0, 1, 0, 1, 22, 0, 1, 22, 20);  // flush
        add_row(3, 0, 0, 0, 1, 0, 1, 23, 0, 0, 23, 22);
        add_row(3, 0, 0, 0, 1, 0, 1, 24, 1, 1, 24, 23);  // flush beats stall
        add_row(3, 0, 0, 0, 1, 0, 1, 25, 0, 0, 25, 24);
        add_row(3, 0, 0, 0, 1, 0, 1, 26, 1, 0, 25, 26);  // stall
        add_row(3, 0, 0, 0, 1, 0, 1, 27, 1, 0, 25, 27);
        add_row(3, 0, 0, 0, 1, 0, 1, 28, 0, 0, 28, 25);
        for (int k = 1; k < 32; k += 2) begin
            add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 0, k, (k + 1) % 32);
        end
    endtask

    task automatic drive_row(int r);
        pcplus4   = t_pc4[r];
        result    = t_res[r];
        uimm      = t_uimm[r];
        memrdata  = t_mdata[r];
        memaddr   = t_maddr[r];
        rddata_sc = t_sc[r];
        csrout    = t_csr[r];
        loadsel   = t_ls[r];
        rdaddr    = t_rd[r];
        resultsrc = t_src[r];
        regw      = t_regw[r];
        iscsr     = t_csrsel[r];
        gototrap  = t_trap[r];
        instret   = t_ret[r];
        rfret     = t_rfret[r];
        en        = t_en[r];
        flush     = t_flush[r];
        rs1addr   = t_rs1[r];
        rs2addr   = t_rs2[r];
    endtask

    task automatic check_xlen(string name, xlen_t got, xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t: row %0d %s is %h, expected %h", $time, cur_row, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, regaddr_t got, regaddr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t: row %0d %s is %0d, expected %0d", $time, cur_row, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t: row %0d %s is %b, expected %b", $time, cur_row, name, got, exp);
        end
    endtask

    task automatic check_trapret(string name, trapret_t got, trapret_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t: row %0d %s is %b, expected %b", $time, cur_row, name, got, exp);
        end
    endtask

    task automatic check_row(int r);
        cur_row = r;
        check_xlen("wbdata", wbdata, e_wb[r]);
        check_bit("regwe", regwe, e_we[r]);
        check_addr("rdaddr_wb", rdaddr_wb, e_rd[r]);
        check_bit("instret_wb", instret_wb, e_ret[r]);
        check_bit("gototrap_wb", gototrap_wb, e_trap[r]);
        check_trapret("returnfromtrap_wb", rfret_wb, e_rfret[r]);
        check_xlen("rs1data", rs1data, e_rs1[r]);
        check_xlen("rs2data", rs2data, e_rs2[r]);
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((n_rows + 20) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        void'($urandom(14));
        rst = 1'b1;
        build_table();
        drive_row(0);
        table_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        cur_row = 0; // after reset, before any capture edge
        check_xlen("wbdata", wbdata, '0);
        check_bit("regwe", regwe, 1'b0);
        check_addr("rdaddr_wb", rdaddr_wb, '0);
        check_bit("instret_wb", instret_wb, 1'b0);
        check_bit("gototrap_wb", gototrap_wb, 1'b0);
        check_trapret("returnfromtrap_wb", rfret_wb, '0);
        for (int a = 0; a < NUM_REGS; a++) begin
            rs1addr = 5'(a);
            rs2addr = 5'(NUM_REGS - 1 - a);
            #1;
            check_xlen("rs1data", rs1data, '0);
            check_xlen("rs2data", rs2data, '0);
        end
        @(negedge clk);
        drive_row(1);
        for (int i = 1; i < n_rows; i++) begin
            @(negedge clk);
            check_row(i);
            if (i + 1 < n_rows) begin
                drive_row(i + 1);
            end
        end
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== riscv_mw.f ====
rtl/riscv_mw_pkg.sv
rtl/riscv_load_align.sv
rtl/riscv_ppreg_mw.sv
rtl/riscv_wb_select.sv
rtl/riscv_regfile.sv
rtl/riscv_mw_top.sv
tests/riscv_mw_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := riscv_mw_tb
FILELIST  := riscv_mw.f
OBJDIR    := obj_dir
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the status of the pipeline is the status of grep
run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJDIR)
